// ==== design/xport_pkg.sv ====
// Shared types for the NI-RIO DMA to CHDR transport adapter
// CHDR header layout, packet and state enums, stream beats, route entries

package xport_pkg;

  //--------------------------------------------------------------------
  // Widths
  //--------------------------------------------------------------------

  // DMA channel index, six channels on the target hardware
  localparam int dma_id_w = 3;
  // CHDR bus word
  localparam int chdr_w   = 64;

  //--------------------------------------------------------------------
  // CHDR header
  //--------------------------------------------------------------------

  // Packet type encoding as carried in the header
  typedef enum logic [2:0] {
    pkt_mgmt    = 3'd0,
    pkt_strs    = 3'd1,
    pkt_strc    = 3'd2,
    pkt_ctrl    = 3'd4,
    pkt_data    = 3'd6,
    pkt_data_ts = 3'd7
  } chdr_pkt_type_e;

  // First word of every CHDR packet, MSB first
  typedef struct packed {
    logic [5:0]     vc;
    logic           eob;
    logic           eov;
    chdr_pkt_type_e pkt_type;
    logic [4:0]     num_mdata;
    logic [15:0]    seq_num;
    logic [15:0]    length;
    logic [15:0]    dst_epid;
  } chdr_hdr_t;

  //--------------------------------------------------------------------
  // Stream beats and route table
  //--------------------------------------------------------------------

  // CHDR side beat
  typedef struct packed {
    logic [chdr_w-1:0] data;
    logic              last;
  } chdr_beat_t;

  // DMA side beat, user is the DMA channel index
  typedef struct packed {
    logic [chdr_w-1:0]   data;
    logic [dma_id_w-1:0] user;
    logic                last;
  } dma_beat_t;

  // Learning write from ingress, one cycle pulse
  typedef struct packed {
    logic                wr_en;
    logic [15:0]         epid;
    logic [dma_id_w-1:0] chan;
  } rt_learn_t;

  // Stored return address with full endpoint ID as tag
  typedef struct packed {
    logic                valid;
    logic [15:0]         tag;
    logic [dma_id_w-1:0] chan;
  } rt_entry_t;

  // Egress FSM
  typedef enum logic [1:0] {eg_hdr, eg_lookup, eg_pass, eg_drop} eg_state_e;

  // Ingress word position within a packet
  typedef enum logic [1:0] {in_hdr, in_word1, in_body} in_state_e;

endpackage

// ==== design/xport_route_table.sv ====
// Direct-mapped return-address table
// Learning write port and registered lookup port

`timescale 1ns/10ps

module xport_route_table #(
  parameter int rt_tbl_size = 6
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  xport_pkg::rt_learn_t   rt_learn,
  input  logic [rt_tbl_size-1:0] rt_rd_idx,
  output xport_pkg::rt_entry_t   rt_rd_entry
);

  import xport_pkg::*;

  localparam int depth = 1 << rt_tbl_size;

  //--------------------------------------------------------------------
  // Storage
  //--------------------------------------------------------------------

  // Valid bits live in flops so they can be cleared together
  logic [depth-1:0]    valid_q;
  // Full endpoint ID per slot, aliases overwrite instead of false hits
  logic [15:0]         tag_mem [depth];
  // Learned DMA channel per slot
  logic [dma_id_w-1:0] chan_mem [depth];

  // Slot selected by the low ID bits
  logic [rt_tbl_size-1:0] wr_idx;

  assign wr_idx = rt_learn.epid[rt_tbl_size-1:0];

  // Valid bits
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_q <= '0;
    end else if (rt_learn.wr_en) begin
      valid_q[wr_idx] <= 1'b1;
    end
  end

  // Tag and channel payload
  always_ff @(posedge clk) begin
    if (rt_learn.wr_en) begin
      tag_mem[wr_idx]  <= rt_learn.epid;
      chan_mem[wr_idx] <= rt_learn.chan;
    end
  end

  //--------------------------------------------------------------------
  // Lookup
  //--------------------------------------------------------------------

  // Registered read
  // A write to the same slot in the same cycle returns the old entry
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rt_rd_entry.valid <= 1'b0;
    end else begin
      rt_rd_entry.valid <= valid_q[rt_rd_idx];
    end
  end

  always_ff @(posedge clk) begin
    rt_rd_entry.tag  <= tag_mem[rt_rd_idx];
    rt_rd_entry.chan <= chan_mem[rt_rd_idx];
  end

endmodule

// ==== design/xport_ingress.sv ====
// DMA to CHDR path with a two-entry skid register
// Extracts route-learning writes from non-data packets

`timescale 1ns/10ps

module xport_ingress (
  input  logic                  clk,
  input  logic                  rst_n,
  input  xport_pkg::dma_beat_t  s_dma,
  input  logic                  s_dma_valid,
  output logic                  s_dma_ready,
  output xport_pkg::chdr_beat_t m_chdr,
  output logic                  m_chdr_valid,
  input  logic                  m_chdr_ready,
  output xport_pkg::rt_learn_t  rt_learn
);

  import xport_pkg::*;

  //--------------------------------------------------------------------
  // Packet tracking
  //--------------------------------------------------------------------

  in_state_e           in_state;
  // Type and channel kept from the header beat
  chdr_pkt_type_e      pkt_type_q;
  logic [dma_id_w-1:0] chan_q;
  // Header view of the incoming word
  chdr_hdr_t           dma_hdr;
  logic                s_accept;
  logic                pkt_is_data;

  assign dma_hdr     = chdr_hdr_t'(s_dma.data);
  assign s_accept    = s_dma_valid && s_dma_ready;
  assign pkt_is_data = (pkt_type_q == pkt_data) || (pkt_type_q == pkt_data_ts);

  // Word position, advanced on each accepted beat
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      in_state <= in_hdr;
    end else if (s_accept) begin
      if (s_dma.last) begin
        in_state <= in_hdr;
      end else if (in_state == in_hdr) begin
        in_state <= in_word1;
      end else begin
        in_state <= in_body;
      end
    end
  end

  // Header fields needed for learning
  always_ff @(posedge clk) begin
    if (s_accept && (in_state == in_hdr)) begin
      pkt_type_q <= dma_hdr.pkt_type;
      chan_q     <= s_dma.user;
    end
  end

  // Source endpoint ID sits in the low 16 bits of word 1
  // Written into the table at the edge that accepts word 1
  always_comb begin
    rt_learn.wr_en = s_accept && (in_state == in_word1) && !pkt_is_data;
    rt_learn.epid  = s_dma.data[15:0];
    rt_learn.chan  = chan_q;
  end

  //--------------------------------------------------------------------
  // Skid register
  //--------------------------------------------------------------------

  // Output stage drives m_chdr, skid stage catches one beat under stall
  logic       out_valid_q;
  chdr_beat_t out_beat_q;
  logic       skid_valid_q;
  chdr_beat_t skid_beat_q;
  chdr_beat_t in_beat;
  logic       out_free;

  // User field is dropped on the way to CHDR
  assign in_beat.data = s_dma.data;
  assign in_beat.last = s_dma.last;

  assign out_free     = !out_valid_q || m_chdr_ready;
  // Ready falls only once both stages hold a beat
  assign s_dma_ready  = !skid_valid_q;
  assign m_chdr       = out_beat_q;
  assign m_chdr_valid = out_valid_q;

  // Stage occupancy
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_valid_q  <= 1'b0;
      skid_valid_q <= 1'b0;
    end else if (out_free) begin
      // Skid drains first, input is stalled meanwhile
      out_valid_q  <= skid_valid_q || s_accept;
      skid_valid_q <= 1'b0;
    end else if (s_accept) begin
      skid_valid_q <= 1'b1;
    end
  end

  // Stage payload
  always_ff @(posedge clk) begin
    if (out_free) begin
      out_beat_q <= skid_valid_q ? skid_beat_q : in_beat;
    end else if (s_accept) begin
      skid_beat_q <= in_beat;
    end
  end

endmodule

// ==== design/xport_egress.sv ====
// CHDR to DMA path with route lookup and channel tagging
// Unroutable packets are discarded and counted

`timescale 1ns/10ps

module xport_egress #(
  parameter int rt_tbl_size = 6
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  xport_pkg::chdr_beat_t  s_chdr,
  input  logic                   s_chdr_valid,
  output logic                   s_chdr_ready,
  output xport_pkg::dma_beat_t   m_dma,
  output logic                   m_dma_valid,
  input  logic                   m_dma_ready,
  output logic [rt_tbl_size-1:0] rt_rd_idx,
  input  xport_pkg::rt_entry_t   rt_rd_entry,
  output logic [15:0]            drop_count
);

  import xport_pkg::*;

  eg_state_e           state;
  // Held header word and its last flag
  chdr_hdr_t           hdr_q;
  logic                hdr_last_q;
  // Table read still in flight
  logic                rd_pend;
  // Header not yet sent on m_dma
  logic                hdr_pend;
  // Channel from the matching entry
  logic [dma_id_w-1:0] chan_q;
  logic                s_accept;
  logic                m_accept;
  logic                rt_hit;
  logic [15:0]         drop_next;

  //--------------------------------------------------------------------
  // Lookup
  //--------------------------------------------------------------------

  // Index is the low ID bits, the tag check below uses the full ID
  assign rt_rd_idx = hdr_q.dst_epid[rt_tbl_size-1:0];
  assign rt_hit    = rt_rd_entry.valid && (rt_rd_entry.tag == hdr_q.dst_epid);

  assign s_accept  = s_chdr_valid && s_chdr_ready;
  assign m_accept  = m_dma_valid && m_dma_ready;

  // Saturating drop counter
  assign drop_next = (drop_count == 16'hffff) ? drop_count : drop_count + 16'd1;

  //--------------------------------------------------------------------
  // Output steering
  //--------------------------------------------------------------------

  always_comb begin
    s_chdr_ready = 1'b0;
    m_dma_valid  = 1'b0;
    // Body beats pass straight through with the learned channel
    m_dma.data   = s_chdr.data;
    m_dma.user   = chan_q;
    m_dma.last   = s_chdr.last;
    case (state)
      eg_hdr, eg_drop: begin
        s_chdr_ready = 1'b1;
      end
      eg_pass: begin
        if (hdr_pend) begin
          // Replay the held header, input stalls
          m_dma_valid = 1'b1;
          m_dma.data  = hdr_q;
          m_dma.last  = hdr_last_q;
        end else begin
          m_dma_valid  = s_chdr_valid;
          s_chdr_ready = m_dma_ready;
        end
      end
      default: begin
        // eg_lookup holds off the input
        s_chdr_ready = 1'b0;
      end
    endcase
  end

  //--------------------------------------------------------------------
  // FSM
  //--------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state      <= eg_hdr;
      rd_pend    <= 1'b0;
      hdr_pend   <= 1'b0;
      drop_count <= '0;
    end else begin
      case (state)
        eg_hdr: begin
          if (s_accept) begin
            state   <= eg_lookup;
            rd_pend <= 1'b1;
          end
        end
        eg_lookup: begin
          if (rd_pend) begin
            // Read issued this cycle, entry arrives next edge
            rd_pend <= 1'b0;
          end else if (rt_hit) begin
            state    <= eg_pass;
            hdr_pend <= 1'b1;
          end else if (hdr_last_q) begin
            // Single-word packet, nothing left to swallow
            state      <= eg_hdr;
            drop_count <= drop_next;
          end else begin
            state <= eg_drop;
          end
        end
        eg_pass: begin
          if (hdr_pend) begin
            if (m_accept) begin
              hdr_pend <= 1'b0;
              if (hdr_last_q) begin
                state <= eg_hdr;
              end
            end
          end else if (m_accept && s_chdr.last) begin
            state <= eg_hdr;
          end
        end
        default: begin
          // eg_drop counts once the last beat is swallowed
          if (s_accept && s_chdr.last) begin
            state      <= eg_hdr;
            drop_count <= drop_next;
          end
        end
      endcase
    end
  end

  // Header capture and channel latch
  always_ff @(posedge clk) begin
    if ((state == eg_hdr) && s_accept) begin
      hdr_q      <= chdr_hdr_t'(s_chdr.data);
      hdr_last_q <= s_chdr.last;
    end
    if ((state == eg_lookup) && !rd_pend) begin
      chan_q <= rt_rd_entry.chan;
    end
  end

endmodule

// ==== design/nirio_chdr64_adapter.sv ====
// NI-RIO DMA to 64-bit CHDR transport adapter top level
// Ingress and egress paths sharing one return-address table

`timescale 1ns/10ps

module nirio_chdr64_adapter #(
  // Log2 of the route table depth
  parameter int rt_tbl_size = 6
) (
  input  logic                  clk,
  input  logic                  rst_n,
  // DMA engines, user carries the channel index
  input  xport_pkg::dma_beat_t  s_dma,
  input  logic                  s_dma_valid,
  output logic                  s_dma_ready,
  output xport_pkg::dma_beat_t  m_dma,
  output logic                  m_dma_valid,
  input  logic                  m_dma_ready,
  // CHDR network
  input  xport_pkg::chdr_beat_t s_chdr,
  input  logic                  s_chdr_valid,
  output logic                  s_chdr_ready,
  output xport_pkg::chdr_beat_t m_chdr,
  output logic                  m_chdr_valid,
  input  logic                  m_chdr_ready,
  // Discarded egress packets, saturating
  output logic [15:0]           drop_count
);

  import xport_pkg::*;

  //--------------------------------------------------------------------
  // Route table links
  //--------------------------------------------------------------------

  rt_learn_t              rt_learn;
  logic [rt_tbl_size-1:0] rt_rd_idx;
  rt_entry_t              rt_rd_entry;

  // DMA to CHDR, learns return channels
  xport_ingress ingress_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .s_dma        (s_dma),
    .s_dma_valid  (s_dma_valid),
    .s_dma_ready  (s_dma_ready),
    .m_chdr       (m_chdr),
    .m_chdr_valid (m_chdr_valid),
    .m_chdr_ready (m_chdr_ready),
    .rt_learn     (rt_learn)
  );

  // CHDR to DMA, steered by destination ID
  xport_egress #(
    .rt_tbl_size (rt_tbl_size)
  ) egress_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .s_chdr       (s_chdr),
    .s_chdr_valid (s_chdr_valid),
    .s_chdr_ready (s_chdr_ready),
    .m_dma        (m_dma),
    .m_dma_valid  (m_dma_valid),
    .m_dma_ready  (m_dma_ready),
    .rt_rd_idx    (rt_rd_idx),
    .rt_rd_entry  (rt_rd_entry),
    .drop_count   (drop_count)
  );

  // Shared return-address table
  xport_route_table #(
    .rt_tbl_size (rt_tbl_size)
  ) route_table_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .rt_learn    (rt_learn),
    .rt_rd_idx   (rt_rd_idx),
    .rt_rd_entry (rt_rd_entry)
  );

endmodule

// ==== tests/nirio_chdr64_adapter_checker.sv ====
// Bound assertions for the transport adapter
// Output handshake hold, outputs after reset, silent egress in drop state

`timescale 1ns/10ps

module nirio_chdr64_adapter_checker (
  input logic                  clk,
  input logic                  rst_n,
  input xport_pkg::dma_beat_t  m_dma,
  input logic                  m_dma_valid,
  input logic                  m_dma_ready,
  input xport_pkg::chdr_beat_t m_chdr,
  input logic                  m_chdr_valid,
  input logic                  m_chdr_ready,
  input xport_pkg::eg_state_e  eg_state
);

  import xport_pkg::*;

  // A stalled DMA beat stays put until taken
  dma_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
    m_dma_valid && !m_dma_ready |=> m_dma_valid && $stable(m_dma))
    else $error("m_dma beat changed or dropped while stalled");

  // Same for the CHDR output stage
  chdr_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
    m_chdr_valid && !m_chdr_ready |=> m_chdr_valid && $stable(m_chdr))
    else $error("m_chdr beat changed or dropped while stalled");

  // Nothing valid right after a reset edge
  reset_idle_a: assert property (@(posedge clk)
    !rst_n |=> !m_dma_valid && !m_chdr_valid)
    else $error("output valid high after reset");

  // Discarded packets never reach the DMA side
  drop_quiet_a: assert property (@(posedge clk) disable iff (!rst_n)
    eg_state == eg_drop |-> !m_dma_valid)
    else $error("m_dma valid while egress discards");

endmodule

bind nirio_chdr64_adapter nirio_chdr64_adapter_checker checker_i (
  .clk          (clk),
  .rst_n        (rst_n),
  .m_dma        (m_dma),
  .m_dma_valid  (m_dma_valid),
  .m_dma_ready  (m_dma_ready),
  .m_chdr       (m_chdr),
  .m_chdr_valid (m_chdr_valid),
  .m_chdr_ready (m_chdr_ready),
  .eg_state     (egress_i.state)
);

// ==== tests/nirio_chdr64_adapter_tb.sv ====
// Testbench for the transport adapter
// Xorshift stimulus, route model, beat scoreboards, per-test report, timeout

`timescale 1ns/10ps

module nirio_chdr64_adapter_tb;

  import xport_pkg::*;

  // Packets over all tests times the longest packet bounds the words sent
  localparam int max_words = 128 * 8;
  localparam int cycle_limit = 4 * max_words + 200;

  logic clk = 1'b0;
  logic rst_n;
  dma_beat_t s_dma, m_dma;
  chdr_beat_t s_chdr, m_chdr;
  logic s_dma_valid, s_dma_ready, m_dma_valid, m_dma_ready;
  logic s_chdr_valid, s_chdr_ready, m_chdr_valid, m_chdr_ready;
  logic [15:0] drop_count;

  nirio_chdr64_adapter #(.rt_tbl_size(4)) uut (.*);

  always #20 clk = ~clk;

  //--------------------------------------------------------------------
  // Model and scoreboards
  //--------------------------------------------------------------------

  logic [31:0] seed = 32'he346;
  // Learned return channel per endpoint ID
  logic [2:0]  learned [logic [15:0]];
  // Shadow of the tagged table, which ID owns each slot
  logic        slot_vld [16];
  logic [15:0] slot_id [16];
  chdr_beat_t  chdr_q [$];
  dma_beat_t   dma_q [$];
  chdr_beat_t  exp_c;
  dma_beat_t   exp_d;
  int drop_exp = 0, errors = 0, cur_err = 0, pass_cnt = 0, fail_cnt = 0;
  int cycles = 0, test_no = 0;
  logic bp_chdr = 1'b0, bp_dma = 1'b0;
  string cur_name;

  function automatic logic [31:0] rnd();
    seed = seed ^ (seed << 13);
    seed = seed ^ (seed >> 17);
    seed = seed ^ (seed << 5);
    return seed;
  endfunction

  function automatic chdr_pkt_type_e pick_type(input logic data_only);
    case (data_only ? 32'd4 + rnd() % 2 : rnd() % 6)
      32'd0:   return pkt_mgmt;
      32'd1:   return pkt_strs;
      32'd2:   return pkt_strc;
      32'd3:   return pkt_ctrl;
      32'd4:   return pkt_data;
      default: return pkt_data_ts;
    endcase
  endfunction

  // Random sink stalls, ready low about a quarter of the time
  always @(negedge clk) begin
    m_chdr_ready = bp_chdr ? ((rnd() % 4) != 0) : 1'b1;
    m_dma_ready  = bp_dma ? ((rnd() % 4) != 0) : 1'b1;
  end

  // Output monitors, beats taken at the rising edge
  always @(posedge clk) begin
    if (rst_n && m_chdr_valid && m_chdr_ready) begin
      if (chdr_q.size() == 0) begin
        errors++;
        $display("ERROR t=%0t unexpected m_chdr beat %h", $time, m_chdr.data);
      end else begin
        exp_c = chdr_q.pop_front();
        if (m_chdr !== exp_c) begin
          errors++;
          $display("ERROR t=%0t m_chdr %h/%b expected %h/%b", $time,
                   m_chdr.data, m_chdr.last, exp_c.data, exp_c.last);
        end
      end
    end
    if (rst_n && m_dma_valid && m_dma_ready) begin
      if (dma_q.size() == 0) begin
        errors++;
        $display("ERROR t=%0t unexpected m_dma beat %h", $time, m_dma.data);
      end else begin
        exp_d = dma_q.pop_front();
        if (m_dma !== exp_d) begin
          errors++;
          $display("ERROR t=%0t m_dma %h/%0d/%b expected %h/%0d/%b", $time,
                   m_dma.data, m_dma.user, m_dma.last,
                   exp_d.data, exp_d.user, exp_d.last);
        end
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > cycle_limit) begin
      $display("Timeout: run did not finish within %0d cycles", cycle_limit);
      $display("sim failed");
      $finish;
    end
  end

  //--------------------------------------------------------------------
  // Drivers
  //--------------------------------------------------------------------

  // Called on a falling edge, returns on the falling edge after transfer
  task automatic put_dma(input dma_beat_t b);
    s_dma = b;
    s_dma_valid = 1'b1;
    @(posedge clk);
    while (!s_dma_ready) @(posedge clk);
    @(negedge clk);
    s_dma_valid = 1'b0;
  endtask

  task automatic put_chdr(input chdr_beat_t b);
    s_chdr = b;
    s_chdr_valid = 1'b1;
    @(posedge clk);
    while (!s_chdr_ready) @(posedge clk);
    @(negedge clk);
    s_chdr_valid = 1'b0;
  endtask

  // DMA packet, source ID in word 1, learned unless it is data
  task automatic send_dma_pkt(input chdr_pkt_type_e t, input logic [2:0] ch,
                              input logic [15:0] src, input int len);
    chdr_hdr_t h;
    dma_beat_t b;
    chdr_beat_t c;
    h = chdr_hdr_t'({rnd(), rnd()});
    h.pkt_type = t;
    h.length = 16'(len * 8);
    for (int i = 0; i < len; i++) begin
      b.data = (i == 0) ? 64'(h) : {rnd(), rnd()};
      if (i == 1) b.data[15:0] = src;
      b.user = ch;
      b.last = (i == len - 1);
      c.data = b.data;
      c.last = b.last;
      chdr_q.push_back(c);
      put_dma(b);
    end
    if (t != pkt_data && t != pkt_data_ts) begin
      learned[src] = ch;
      slot_vld[src[3:0]] = 1'b1;
      slot_id[src[3:0]] = src;
    end
  endtask

  // CHDR packet, expected on m_dma only if the shadow table hits
  task automatic send_chdr_pkt(input logic [15:0] dst, input int len);
    chdr_hdr_t h;
    chdr_beat_t b;
    dma_beat_t d;
    logic hit;
    h = chdr_hdr_t'({rnd(), rnd()});
    h.pkt_type = pkt_data;
    h.dst_epid = dst;
    h.length = 16'(len * 8);
    hit = slot_vld[dst[3:0]] && (slot_id[dst[3:0]] == dst);
    if (!hit) drop_exp++;
    for (int i = 0; i < len; i++) begin
      b.data = (i == 0) ? 64'(h) : {rnd(), rnd()};
      b.last = (i == len - 1);
      if (hit) begin
        d.data = b.data;
        d.user = learned[dst];
        d.last = b.last;
        dma_q.push_back(d);
      end
      put_chdr(b);
    end
  endtask

  function automatic int rand_len();
    return 2 + int'(rnd() % 7);
  endfunction

  //--------------------------------------------------------------------
  // Test bookkeeping
  //--------------------------------------------------------------------

  task automatic start_test(input string name);
    test_no++;
    cur_name = name;
    cur_err = errors;
  endtask

  // Waits for both scoreboards to empty, then checks the drop counter
  task automatic finish_test();
    while (chdr_q.size() != 0 || dma_q.size() != 0) @(negedge clk);
    if (drop_count !== 16'(drop_exp)) begin
      errors++;
      $display("ERROR t=%0t drop_count %0d expected %0d", $time, drop_count, drop_exp);
    end
    if (errors == cur_err) pass_cnt++;
    else fail_cnt++;
    $display("test %0d %s: %s", test_no, cur_name, (errors == cur_err) ? "ok" : "FAILED");
  endtask

  initial begin
    rst_n = 1'b0;
    s_dma = '0;
    s_dma_valid = 1'b0;
    s_chdr = '0;
    s_chdr_valid = 1'b0;
    m_dma_ready = 1'b1;
    m_chdr_ready = 1'b1;
    for (int i = 0; i < 16; i++) slot_vld[i] = 1'b0;
    repeat (5) @(negedge clk);
    rst_n = 1'b1;

    start_test("ingress pass-through");
    bp_chdr = 1'b1;
    for (int i = 0; i < 40; i++)
      send_dma_pkt(pick_type(1'b0), 3'(rnd() % 6), 16'(rnd() & 32'h0fff), rand_len());
    finish_test();

    // IDs 0x1000 to 0x1005 fill slots 0 to 5 from channels 0 to 5
    start_test("learning and steering");
    for (int k = 0; k < 6; k++) send_dma_pkt(pkt_ctrl, 3'(k), 16'(32'h1000 + k), 2);
    while (chdr_q.size() != 0) @(negedge clk);
    bp_dma = 1'b1;
    for (int k = 0; k < 6; k++) send_chdr_pkt(16'(32'h1005 - k), rand_len());
    finish_test();

    // High nibble F is never learned
    start_test("miss discard");
    for (int i = 0; i < 8; i++) send_chdr_pkt(16'(32'hf000 | (rnd() & 32'hff)), rand_len());
    finish_test();

    start_test("data does not learn");
    send_dma_pkt(pkt_data_ts, 3'd2, 16'h2349, 3);
    while (chdr_q.size() != 0) @(negedge clk);
    send_chdr_pkt(16'h2349, 3);
    finish_test();

    // Relearn 0x3008 on channel 5, then evict it with alias 0x3108
    start_test("relearning and aliasing");
    send_dma_pkt(pkt_mgmt, 3'd3, 16'h3008, 2);
    send_dma_pkt(pkt_strs, 3'd5, 16'h3008, 3);
    while (chdr_q.size() != 0) @(negedge clk);
    send_chdr_pkt(16'h3008, 4);
    send_dma_pkt(pkt_strc, 3'd1, 16'h3108, 2);
    while (chdr_q.size() != 0) @(negedge clk);
    send_chdr_pkt(16'h3008, 3);
    send_chdr_pkt(16'h3108, 5);
    finish_test();

    // Ingress carries data only, so the table is stable during lookups
    start_test("back-pressure on both paths");
    fork
      for (int i = 0; i < 30; i++)
        send_dma_pkt(pick_type(1'b1), 3'(rnd() % 6), 16'(rnd()), rand_len());
      for (int i = 0; i < 30; i++)
        send_chdr_pkt((rnd() % 2 == 0) ? 16'(32'h1000 + rnd() % 6) : 16'(32'hf000 | (rnd() & 32'hff)),
                      rand_len());
    join
    finish_test();

    $display("%0d tests: %0d ok, %0d failed", test_no, pass_cnt, fail_cnt);
    if (fail_cnt == 0 && errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// ==== nirio_chdr64_adapter.f ====
design/xport_pkg.sv
design/xport_route_table.sv
design/xport_ingress.sv
design/xport_egress.sv
design/nirio_chdr64_adapter.sv
tests/nirio_chdr64_adapter_checker.sv
tests/nirio_chdr64_adapter_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = nirio_chdr64_adapter_tb
FILELIST  = nirio_chdr64_adapter.f
LOG       = sim.log
OBJ_DIR   = obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "sim passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
